//--- build.f
+incdir+dv
source/decode_pkg.sv
source/control.sv
source/operand_extract.sv
source/decode_stage.sv
source/decode_top.sv
dv/decode_tb.sv

//--- dv/decode_vectors.svh
`ifndef DECODE_VECTORS_SVH
`define DECODE_VECTORS_SVH

typedef struct packed {
    logic [WORD_W-1:0]   instr;
    logic [REG_W-1:0]    write_reg;
    logic [WORD_W-1:0]   imm;
    logic                reg_write;
    logic [ALU_OP_W-1:0] alu_op;
    logic [1:0]          pc_dec;
    logic                mem_read;
    logic                mem_write;
    logic [3:0]          br;          // branch, eqz, gtz, ltz
    logic                err;
    logic                halt;
    logic [1:0]          alu_src_a;
    logic [1:0]          alu_src_b;
    logic                sign_alu;
    logic [1:0]          set_select;
    logic                alu_res_sel;
    logic [1:0]          mem_to_reg;
} decode_row_t;

localparam int N_VECTORS = 30;

decode_row_t rows [N_VECTORS];

task automatic load_vectors;
    // instr, write_reg, imm, reg_write, alu_op, pc_dec, mem rd wr, br flags, err halt
    // then alu_src_a, alu_src_b, sign_alu, set_select, alu_res_sel, mem_to_reg
    rows[0]  = {16'h415D, 3'd2, 16'hFFFD, 1'b1, 4'b1100, 2'b00, 2'b00, 4'b0000, 2'b00,
                2'b00, 2'b01, 1'b1, 2'b00, 1'b0, 2'b01}; // ADDI
    rows[1]  = {16'h4B85, 3'd4, 16'h0005, 1'b1, 4'b1101, 2'b00, 2'b00, 4'b0000, 2'b00,
                2'b00, 2'b01, 1'b1, 2'b00, 1'b0, 2'b01}; // SUBI
    rows[2]  = {16'h55D3, 3'd6, 16'h0013, 1'b1, 4'b1110, 2'b00, 2'b00, 4'b0000, 2'b00,
                2'b00, 2'b01, 1'b1, 2'b00, 1'b0, 2'b01}; // XORI
    rows[3]  = {16'h58FF, 3'd7, 16'h001F, 1'b1, 4'b1111, 2'b00, 2'b00, 4'b0000, 2'b00,
                2'b00, 2'b01, 1'b1, 2'b00, 1'b0, 2'b01}; // ANDNI
    rows[4]  = {16'hA264, 3'd3, 16'h0004, 1'b1, 4'b1000, 2'b00, 2'b00, 4'b0000, 2'b00,
                2'b00, 2'b01, 1'b0, 2'b00, 1'b0, 2'b01}; // ROLI
    rows[5]  = {16'hB93F, 3'd1, 16'hFFFF, 1'b1, 4'b1011, 2'b00, 2'b00, 4'b0000, 2'b00,
                2'b00, 2'b01, 1'b0, 2'b00, 1'b0, 2'b01}; // SRLI
    rows[6]  = {16'h84B0, 3'd4, 16'hFFF0, 1'b0, 4'b1100, 2'b00, 2'b11, 4'b0000, 2'b00,
                2'b00, 2'b01, 1'b1, 2'b00, 1'b0, 2'b01}; // ST
    rows[7]  = {16'h9E23, 3'd6, 16'h0003, 1'b1, 4'b1100, 2'b00, 2'b11, 4'b0000, 2'b00,
                2'b00, 2'b01, 1'b1, 2'b00, 1'b0, 2'b01}; // STU
    rows[8]  = {16'h8F58, 3'd2, 16'hFFF8, 1'b1, 4'b1100, 2'b00, 2'b10, 4'b0000, 2'b00,
                2'b00, 2'b01, 1'b1, 2'b00, 1'b0, 2'b00}; // LD
    rows[9]  = {16'hCB14, 3'd5, 16'hFFF4, 1'b1, 4'b1001, 2'b00, 2'b00, 4'b0000, 2'b00,
                2'b10, 2'b10, 1'b0, 2'b00, 1'b0, 2'b01}; // BTR
    rows[10] = {16'hD14C, 3'd3, 16'h000C, 1'b1, 4'b0000, 2'b00, 2'b00, 4'b0000, 2'b00,
                2'b00, 2'b00, 1'b0, 2'b00, 1'b0, 2'b01}; // ADD
    rows[11] = {16'hDCBB, 3'd6, 16'hFFFB, 1'b1, 4'b0100, 2'b00, 2'b00, 4'b0000, 2'b00,
                2'b00, 2'b00, 1'b0, 2'b00, 1'b0, 2'b01}; // SRL
    rows[12] = {16'hE15C, 3'd7, 16'hFFFC, 1'b1, 4'b1101, 2'b00, 2'b00, 4'b0000, 2'b00,
                2'b00, 2'b00, 1'b1, 2'b00, 1'b1, 2'b01}; // SEQ
    rows[13] = {16'hE804, 3'd1, 16'h0004, 1'b1, 4'b1101, 2'b00, 2'b00, 4'b0000, 2'b00,
                2'b00, 2'b00, 1'b0, 2'b01, 1'b1, 2'b01}; // SLT
    rows[14] = {16'hF270, 3'd4, 16'hFFF0, 1'b1, 4'b1101, 2'b00, 2'b00, 4'b0000, 2'b00,
                2'b00, 2'b00, 1'b0, 2'b10, 1'b1, 2'b01}; // SLE
    rows[15] = {16'hFDC8, 3'd2, 16'h0008, 1'b1, 4'b1100, 2'b00, 2'b00, 4'b0000, 2'b00,
                2'b00, 2'b00, 1'b1, 2'b11, 1'b1, 2'b01}; // SCO
    rows[16] = {16'h62F0, 3'd2, 16'hFFF0, 1'b0, 4'b1100, 2'b01, 2'b00, 4'b1100, 2'b00,
                2'b00, 2'b10, 1'b1, 2'b00, 1'b0, 2'b01}; // BEQZ
    rows[17] = {16'h6B10, 3'd3, 16'h0010, 1'b0, 4'b1100, 2'b01, 2'b00, 4'b1011, 2'b00,
                2'b00, 2'b10, 1'b1, 2'b00, 1'b0, 2'b01}; // BNEZ
    rows[18] = {16'h7480, 3'd4, 16'hFF80, 1'b0, 4'b1100, 2'b01, 2'b00, 4'b1001, 2'b00,
                2'b00, 2'b10, 1'b1, 2'b00, 1'b0, 2'b01}; // BLTZ
    rows[19] = {16'h7D7F, 3'd5, 16'h007F, 1'b0, 4'b1100, 2'b01, 2'b00, 4'b1110, 2'b00,
                2'b00, 2'b10, 1'b1, 2'b00, 1'b0, 2'b01}; // BGEZ
    rows[20] = {16'hC69C, 3'd6, 16'hFF9C, 1'b1, 4'b0000, 2'b00, 2'b00, 4'b0000, 2'b00,
                2'b00, 2'b01, 1'b1, 2'b00, 1'b0, 2'b11}; // LBI
    rows[21] = {16'h9125, 3'd1, 16'h0025, 1'b1, 4'b1001, 2'b00, 2'b00, 4'b0000, 2'b00,
                2'b01, 2'b10, 1'b0, 2'b00, 1'b0, 2'b01}; // SLBI
    rows[22] = {16'h27FE, 3'd7, 16'hFFFE, 1'b0, 4'b1100, 2'b10, 2'b00, 4'b0000, 2'b00,
                2'b00, 2'b00, 1'b1, 2'b00, 1'b0, 2'b01}; // J
    rows[23] = {16'h2A04, 3'd2, 16'h0004, 1'b0, 4'b1100, 2'b11, 2'b00, 4'b0000, 2'b00,
                2'b00, 2'b01, 1'b1, 2'b00, 1'b0, 2'b01}; // JR
    rows[24] = {16'h3123, 3'd7, 16'h0123, 1'b1, 4'b1100, 2'b10, 2'b00, 4'b0000, 2'b00,
                2'b00, 2'b00, 1'b1, 2'b00, 1'b0, 2'b10}; // JAL
    rows[25] = {16'h3BFC, 3'd7, 16'hFFFC, 1'b1, 4'b1100, 2'b11, 2'b00, 4'b0000, 2'b00,
                2'b00, 2'b01, 1'b1, 2'b00, 1'b0, 2'b10}; // JALR
    rows[26] = {16'h0000, 3'd0, 16'h0000, 1'b0, 4'b0000, 2'b00, 2'b00, 4'b0000, 2'b01,
                2'b00, 2'b00, 1'b0, 2'b00, 1'b0, 2'b01}; // HALT
    rows[27] = {16'h0D55, 3'd5, 16'hFFF5, 1'b0, 4'b0000, 2'b00, 2'b00, 4'b0000, 2'b00,
                2'b00, 2'b00, 1'b0, 2'b00, 1'b0, 2'b01}; // NOP
    rows[28] = {16'h1000, 3'd0, 16'h0000, 1'b0, 4'b0000, 2'b00, 2'b00, 4'b0000, 2'b00,
                2'b00, 2'b00, 1'b0, 2'b00, 1'b0, 2'b01}; // SIIC
    rows[29] = {16'h1800, 3'd0, 16'h0000, 1'b0, 4'b0000, 2'b00, 2'b00, 4'b0000, 2'b00,
                2'b00, 2'b00, 1'b0, 2'b00, 1'b0, 2'b01}; // RTI
endtask

`endif

//--- dv/decode_tb.sv
`timescale 1ns/1ps
`default_nettype none

module decode_tb import decode_pkg::*; ();

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 16;
    localparam int N_RANDOM     = 40;
    localparam int N_STALL      = 4;

    logic                clk, rst_n, in_valid, stall;
    logic [WORD_W-1:0]   instr;
    logic                ready, out_valid;
    logic [REG_W-1:0]    write_reg, read_reg_a, read_reg_b;
    logic [WORD_W-1:0]   imm;
    logic [1:0]          alu_src_a_q, alu_src_b_q, set_select_q, mem_to_reg_q, pc_dec_q;
    logic [ALU_OP_W-1:0] alu_op_q;
    logic                reg_write_q, sign_alu_q, alu_res_sel_q, branch_q;
    logic                branch_eqz_q, branch_gtz_q, branch_ltz_q;
    logic                mem_read_q, mem_write_q, err_q, halt_q, createdump_q;
    integer              seed;

    `include "decode_vectors.svh"

    decode_top uut (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Random words take two cycles each
    initial begin
        #(4 * (N_VECTORS + 2 * N_RANDOM + N_STALL + RESET_CYCLES + 8) * CLK_PERIOD);
        $display("Timeout: the decode stage never finished the test sequence");
        $display("Test failed");
        $fatal(1, "watchdog expired");
    end

    task automatic check_reg(input string name, input logic [REG_W-1:0] exp,
                             input logic [REG_W-1:0] act);
        if (act !== exp) begin
            $display("[ERROR] time %0t: %s expected %0d got %0d", $time, name, exp, act);
            $display("Test failed");
            $fatal(1, "register specifier mismatch");
        end
    endtask

    task automatic check_word(input string name, input logic [WORD_W-1:0] exp,
                              input logic [WORD_W-1:0] act);
        if (act !== exp) begin
            $display("[ERROR] time %0t: %s expected %h got %h", $time, name, exp, act);
            $display("Test failed");
            $fatal(1, "word mismatch");
        end
    endtask

    task automatic check_op(input string name, input logic [ALU_OP_W-1:0] exp,
                            input logic [ALU_OP_W-1:0] act);
        if (act !== exp) begin
            $display("[ERROR] time %0t: %s expected %b got %b", $time, name, exp, act);
            $display("Test failed");
            $fatal(1, "ALU op mismatch");
        end
    endtask

    task automatic check_code(input string name, input logic [1:0] exp, input logic [1:0] act);
        if (act !== exp) begin
            $display("[ERROR] time %0t: %s expected %b got %b", $time, name, exp, act);
            $display("Test failed");
            $fatal(1, "select code mismatch");
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("[ERROR] time %0t: %s expected %b got %b", $time, name, exp, act);
            $display("Test failed");
            $fatal(1, "flag mismatch");
        end
    endtask

    task automatic check_idle;
        check_flag("out_valid", 1'b0, out_valid);
        check_flag("reg_write", 1'b0, reg_write_q);
        check_flag("mem_read", 1'b0, mem_read_q);
        check_flag("mem_write", 1'b0, mem_write_q);
        check_flag("branch", 1'b0, branch_q);
        check_flag("halt", 1'b0, halt_q);
        check_flag("err", 1'b0, err_q);
        check_flag("createdump", 1'b0, createdump_q);
        check_word("imm", '0, imm);
    endtask

    task automatic check_row(input decode_row_t r);
        check_flag("out_valid", 1'b1, out_valid);
        check_reg("write_reg", r.write_reg, write_reg);
        check_reg("read_reg_a", r.instr[10:8], read_reg_a);
        check_reg("read_reg_b", r.instr[7:5], read_reg_b);
        check_word("imm", r.imm, imm);
        check_flag("reg_write", r.reg_write, reg_write_q);
        check_op("alu_op", r.alu_op, alu_op_q);
        check_code("pc_dec", r.pc_dec, pc_dec_q);
        check_flag("mem_read", r.mem_read, mem_read_q);
        check_flag("mem_write", r.mem_write, mem_write_q);
        check_flag("branch", r.br[3], branch_q);
        check_flag("branch_eqz", r.br[2], branch_eqz_q);
        check_flag("branch_gtz", r.br[1], branch_gtz_q);
        check_flag("branch_ltz", r.br[0], branch_ltz_q);
        check_flag("err", r.err, err_q);
        check_flag("halt", r.halt, halt_q);
        check_flag("createdump", r.halt, createdump_q);  // HALT raises both
        check_code("alu_src_a", r.alu_src_a, alu_src_a_q);
        check_code("alu_src_b", r.alu_src_b, alu_src_b_q);
        check_flag("sign_alu", r.sign_alu, sign_alu_q);
        check_code("set_select", r.set_select, set_select_q);
        check_flag("alu_res_sel", r.alu_res_sel, alu_res_sel_q);
        check_code("mem_to_reg", r.mem_to_reg, mem_to_reg_q);
    endtask

    // Words go in back to back and each is checked one cycle later
    task automatic run_table;
        @(negedge clk);
        instr    = rows[0].instr;
        in_valid = 1'b1;
        for (int i = 1; i <= N_VECTORS; i++) begin
            @(negedge clk);
            check_row(rows[i-1]);
            if (i < N_VECTORS)
                instr = rows[i].instr;
            else
                in_valid = 1'b0;
        end
        @(negedge clk);
        check_flag("out_valid", 1'b0, out_valid);  // Bubble
    endtask

    task automatic random_format_checks;
        logic [31:0]       bits;
        logic [OP_W-1:0]   op;
        logic [REG_W-1:0]  exp_reg;
        logic [WORD_W-1:0] exp_imm;
        for (int i = 0; i < N_RANDOM; i++) begin
            bits = $random(seed);
            case (i % 5)
                0: begin                            // ADDI
                    op      = 5'b01000;
                    exp_reg = bits[7:5];
                    exp_imm = 16'($signed(bits[4:0]));
                end
                1: begin                            // XORI
                    op      = 5'b01010;
                    exp_reg = bits[7:5];
                    exp_imm = {11'b0, bits[4:0]};
                end
                2: begin
                    op      = OP_LBI;
                    exp_reg = bits[10:8];
                    exp_imm = 16'($signed(bits[7:0]));
                end
                3: begin
                    op      = OP_JAL;
                    exp_reg = 3'd7;
                    exp_imm = 16'($signed(bits[10:0]));
                end
                default: begin                      // ADD in R-format
                    op      = 5'b11010;
                    exp_reg = bits[4:2];
                    exp_imm = 16'($signed(bits[4:0]));
                end
            endcase
            @(negedge clk);
            instr    = {op, bits[10:0]};
            in_valid = 1'b1;
            @(negedge clk);
            check_flag("out_valid", 1'b1, out_valid);
            check_reg("write_reg", exp_reg, write_reg);
            check_word("imm", exp_imm, imm);
        end
    endtask

    task automatic stall_check;
        @(negedge clk);
        instr    = rows[8].instr;                   // LD
        in_valid = 1'b1;
        @(negedge clk);
        check_row(rows[8]);
        stall    = 1'b1;
        in_valid = 1'b0;                            // out_valid still holds
        for (int k = 0; k < N_STALL; k++) begin
            @(negedge clk);
            check_row(rows[8]);
            check_flag("ready", 1'b0, ready);
            instr = rows[k].instr;
        end
        instr    = rows[16].instr;                  // BEQZ
        in_valid = 1'b1;
        stall    = 1'b0;
        @(negedge clk);
        check_flag("ready", 1'b1, ready);
        check_row(rows[16]);
        in_valid = 1'b0;
        @(negedge clk);
        check_flag("out_valid", 1'b0, out_valid);
    endtask

    initial begin
        seed     = 8;
        rst_n    = 1'b0;
        in_valid = 1'b0;
        stall    = 1'b0;
        instr    = '0;
        load_vectors();
        repeat (RESET_CYCLES) @(negedge clk);
        check_idle();
        rst_n = 1'b1;
        @(negedge clk);
        check_idle();
        run_table();
        random_format_checks();
        stall_check();
        $display("Test completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the decode stage testbench with Verilator.
# The exit status is nonzero when the testbench ends in $fatal.

cd "$(dirname "$0")" &&
verilator --binary --timing -j 0 -f build.f --top-module decode_tb -o decode_sim &&
./obj_dir/decode_sim &&
echo "Simulation passed" ||
{
    echo "Simulation failed"
    exit 1
}

//--- source/control.sv
`timescale 1ns/1ps
`default_nettype none

module control import decode_pkg::*; (
    input  logic [OP_W-1:0]     opcode,
    output logic [1:0]          reg_dst,
    output logic                reg_write,
    output logic [1:0]          imm_sel,
    output logic [1:0]          alu_src_a,
    output logic [1:0]          alu_src_b,
    output logic                sign_alu,
    output logic [ALU_OP_W-1:0] alu_op,
    output logic [1:0]          set_select,
    output logic                alu_res_sel,
    output logic [1:0]          mem_to_reg,
    output logic [1:0]          pc_dec,
    output logic                branch,
    output logic                branch_eqz,
    output logic                branch_gtz,
    output logic                branch_ltz,
    output logic                mem_read,
    output logic                mem_write,
    output logic                err,
    output logic                halt,
    output logic                createdump
);

    always_comb begin
        // Idle decode, opcodes override below
        reg_dst     = DST_RS;
        reg_write   = 1'b0;
        imm_sel     = IMM_S5;
        alu_src_a   = 2'b00;
        alu_src_b   = 2'b00;
        sign_alu    = 1'b0;
        alu_op      = '0;
        set_select  = 2'b00;
        alu_res_sel = 1'b0;
        mem_to_reg  = 2'b01;          // ALU result
        pc_dec      = PC_SEQ;
        branch      = 1'b0;
        branch_eqz  = 1'b0;
        branch_gtz  = 1'b0;
        branch_ltz  = 1'b0;
        mem_read    = 1'b0;
        mem_write   = 1'b0;
        err         = 1'b0;
        halt        = 1'b0;
        createdump  = 1'b0;

        case (opcode) inside
            OP_HALT: begin
                halt       = 1'b1;
                createdump = 1'b1;
            end

            OP_NOP, OP_SIIC, OP_RTI: begin
                // No exception state in this stage
            end

            OP_IMM_ARITH, OP_IMM_LOGIC: begin
                reg_dst   = DST_I_RD;
                reg_write = 1'b1;
                imm_sel   = opcode[1] ? IMM_Z5 : IMM_S5;  // Logic ops zero extend
                alu_src_b = 2'b01;
                sign_alu  = 1'b1;
                alu_op    = {2'b11, opcode[1:0]};
            end

            OP_IMM_SHIFT: begin
                reg_dst   = DST_I_RD;
                reg_write = 1'b1;
                alu_src_b = 2'b01;
                alu_op    = {2'b10, opcode[1:0]};
            end

            OP_ST, OP_STU: begin
                reg_write = (opcode == OP_STU);         // STU updates rs
                alu_src_b = 2'b01;
                sign_alu  = 1'b1;
                alu_op    = 4'b1100;
                mem_read  = 1'b1;
                mem_write = 1'b1;
            end

            OP_LD: begin
                reg_dst    = DST_I_RD;
                reg_write  = 1'b1;
                alu_src_b  = 2'b01;
                sign_alu   = 1'b1;
                alu_op     = 4'b1100;
                mem_to_reg = 2'b00;                     // Load data
                mem_read   = 1'b1;
            end

            OP_BTR: begin
                reg_dst   = DST_R_RD;
                reg_write = 1'b1;
                alu_src_a = 2'b10;
                alu_src_b = 2'b10;
                alu_op    = 4'b1001;
            end

            OP_ALU: begin
                reg_dst   = DST_R_RD;
                reg_write = 1'b1;
                alu_op    = {1'b0, opcode[0], 2'b00};
            end

            OP_SEQ, OP_SLT, OP_SLE, OP_SCO: begin
                reg_dst     = DST_R_RD;
                reg_write   = 1'b1;
                sign_alu    = (opcode[1] == opcode[0]);  // SEQ and SCO
                alu_op      = (opcode == OP_SCO) ? 4'b1100 : 4'b1101;
                set_select  = opcode[1:0];
                alu_res_sel = 1'b1;
            end

            OP_BEQZ, OP_BNEZ, OP_BLTZ, OP_BGEZ: begin
                imm_sel    = IMM_S8;
                alu_src_b  = 2'b10;
                sign_alu   = 1'b1;
                alu_op     = 4'b1100;
                pc_dec     = PC_BRANCH;
                branch     = 1'b1;
                // Taken when rs compares as flagged
                branch_eqz = (opcode == OP_BEQZ) || (opcode == OP_BGEZ);
                branch_gtz = (opcode == OP_BNEZ) || (opcode == OP_BGEZ);
                branch_ltz = (opcode == OP_BNEZ) || (opcode == OP_BLTZ);
            end

            OP_LBI: begin
                reg_write  = 1'b1;
                imm_sel    = IMM_S8;
                alu_src_b  = 2'b01;
                sign_alu   = 1'b1;
                mem_to_reg = 2'b11;                     // Immediate straight to rs
            end

            OP_SLBI: begin
                reg_write = 1'b1;
                imm_sel   = IMM_S8;
                alu_src_a = 2'b01;                      // Shift and or
                alu_src_b = 2'b10;
                alu_op    = 4'b1001;
            end

            OP_J, OP_JR, OP_JAL, OP_JALR: begin
                sign_alu = 1'b1;
                alu_op   = 4'b1100;
                if (opcode[0]) begin                    // Register relative
                    imm_sel   = IMM_S8;
                    alu_src_b = 2'b01;
                    pc_dec    = PC_JUMP_REG;
                end else begin
                    imm_sel = IMM_S11;
                    pc_dec  = PC_JUMP;
                end
                if (opcode[1]) begin                    // Link into R7
                    reg_dst    = DST_R7;
                    reg_write  = 1'b1;
                    mem_to_reg = 2'b10;
                end
            end

            default: err = 1'b1;
        endcase
    end

endmodule

`default_nettype wire

//--- source/decode_pkg.sv
`default_nettype none

package decode_pkg;

    localparam int OP_W     = 5;
    localparam int REG_W    = 3;
    localparam int WORD_W   = 16;
    localparam int ALU_OP_W = 4;

    // Opcode map, upper five bits of the word
    localparam logic [OP_W-1:0] OP_HALT      = 5'b0_0000;
    localparam logic [OP_W-1:0] OP_NOP       = 5'b0_0001;
    localparam logic [OP_W-1:0] OP_SIIC      = 5'b0_0010;
    localparam logic [OP_W-1:0] OP_RTI       = 5'b0_0011;
    localparam logic [OP_W-1:0] OP_J         = 5'b0_0100;
    localparam logic [OP_W-1:0] OP_JR        = 5'b0_0101;
    localparam logic [OP_W-1:0] OP_JAL       = 5'b0_0110;
    localparam logic [OP_W-1:0] OP_JALR      = 5'b0_0111;
    localparam logic [OP_W-1:0] OP_IMM_ARITH = 5'b0_100?;
    localparam logic [OP_W-1:0] OP_IMM_LOGIC = 5'b0_101?;
    localparam logic [OP_W-1:0] OP_BEQZ      = 5'b0_1100;
    localparam logic [OP_W-1:0] OP_BNEZ      = 5'b0_1101;
    localparam logic [OP_W-1:0] OP_BLTZ      = 5'b0_1110;
    localparam logic [OP_W-1:0] OP_BGEZ      = 5'b0_1111;
    localparam logic [OP_W-1:0] OP_ST        = 5'b1_0000;
    localparam logic [OP_W-1:0] OP_LD        = 5'b1_0001;
    localparam logic [OP_W-1:0] OP_SLBI      = 5'b1_0010;
    localparam logic [OP_W-1:0] OP_STU       = 5'b1_0011;
    localparam logic [OP_W-1:0] OP_IMM_SHIFT = 5'b1_01??;
    localparam logic [OP_W-1:0] OP_LBI       = 5'b1_1000;
    localparam logic [OP_W-1:0] OP_BTR       = 5'b1_1001;
    localparam logic [OP_W-1:0] OP_ALU       = 5'b1_101?;
    localparam logic [OP_W-1:0] OP_SEQ       = 5'b1_1100;
    localparam logic [OP_W-1:0] OP_SLT       = 5'b1_1101;
    localparam logic [OP_W-1:0] OP_SLE       = 5'b1_1110;
    localparam logic [OP_W-1:0] OP_SCO       = 5'b1_1111;

    // Write register select
    localparam logic [1:0] DST_RS   = 2'b00;
    localparam logic [1:0] DST_R_RD = 2'b01;
    localparam logic [1:0] DST_R7   = 2'b10;
    localparam logic [1:0] DST_I_RD = 2'b11;

    // Immediate select
    localparam logic [1:0] IMM_S5  = 2'b00;
    localparam logic [1:0] IMM_S8  = 2'b01;
    localparam logic [1:0] IMM_Z5  = 2'b10;
    localparam logic [1:0] IMM_S11 = 2'b11;

    // Next PC source
    localparam logic [1:0] PC_SEQ      = 2'b00;
    localparam logic [1:0] PC_BRANCH   = 2'b01;
    localparam logic [1:0] PC_JUMP     = 2'b10;
    localparam logic [1:0] PC_JUMP_REG = 2'b11;

    typedef struct packed {
        logic [OP_W-1:0]  op;
        logic [REG_W-1:0] rs;
        logic [REG_W-1:0] rd;
        logic [4:0]       imm5;
    } i1_fmt_t;

    typedef struct packed {
        logic [OP_W-1:0]  op;
        logic [REG_W-1:0] rs;
        logic [7:0]       imm8;
    } i2_fmt_t;

    typedef struct packed {
        logic [OP_W-1:0]  op;
        logic [REG_W-1:0] rs;
        logic [REG_W-1:0] rt;
        logic [REG_W-1:0] rd;
        logic [1:0]       func;
    } r_fmt_t;

    typedef struct packed {
        logic [OP_W-1:0] op;
        logic [10:0]     disp11;
    } j_fmt_t;

    // One 16-bit word, four readings
    typedef union packed {
        i1_fmt_t i1;
        i2_fmt_t i2;
        r_fmt_t  r;
        j_fmt_t  j;
    } instr_word_t;

endpackage

`default_nettype wire

//--- source/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage import decode_pkg::*; (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                in_valid,
    input  logic                stall,
    input  logic [1:0]          reg_dst,
    input  logic [1:0]          imm_sel,
    input  logic [1:0]          alu_src_a,
    input  logic [1:0]          alu_src_b,
    input  logic [1:0]          set_select,
    input  logic [1:0]          mem_to_reg,
    input  logic [1:0]          pc_dec,
    input  logic [ALU_OP_W-1:0] alu_op,
    input  logic                reg_write, sign_alu, alu_res_sel, branch,
    input  logic                branch_eqz, branch_gtz, branch_ltz,
    input  logic                mem_read, mem_write, err, halt, createdump,
    input  logic [REG_W-1:0]    rs, rt, rd_i, rd_r,
    input  logic [WORD_W-1:0]   imm_s5, imm_z5, imm_s8, imm_s11,
    output logic                out_valid,
    output logic [REG_W-1:0]    write_reg, read_reg_a, read_reg_b,
    output logic [WORD_W-1:0]   imm,
    output logic [1:0]          alu_src_a_q, alu_src_b_q, set_select_q,
    output logic [1:0]          mem_to_reg_q, pc_dec_q,
    output logic [ALU_OP_W-1:0] alu_op_q,
    output logic                reg_write_q, sign_alu_q, alu_res_sel_q, branch_q,
    output logic                branch_eqz_q, branch_gtz_q, branch_ltz_q,
    output logic                mem_read_q, mem_write_q, err_q, halt_q, createdump_q
);

    logic [REG_W-1:0]  sel_write_reg;
    logic [WORD_W-1:0] sel_imm;
    logic              accept;

    assign accept = in_valid && !stall;

    always_comb begin
        case (reg_dst)
            DST_RS:   sel_write_reg = rs;
            DST_R_RD: sel_write_reg = rd_r;
            DST_R7:   sel_write_reg = {REG_W{1'b1}};  // Link register
            DST_I_RD: sel_write_reg = rd_i;
        endcase
    end

    always_comb begin
        case (imm_sel)
            IMM_S5:  sel_imm = imm_s5;
            IMM_S8:  sel_imm = imm_s8;
            IMM_Z5:  sel_imm = imm_z5;
            IMM_S11: sel_imm = imm_s11;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            {write_reg, read_reg_a, read_reg_b, imm} <= '0;
            {alu_src_a_q, alu_src_b_q, set_select_q, mem_to_reg_q, pc_dec_q, alu_op_q} <= '0;
            {reg_write_q, sign_alu_q, alu_res_sel_q, branch_q} <= '0;
            {branch_eqz_q, branch_gtz_q, branch_ltz_q} <= '0;
            {mem_read_q, mem_write_q, err_q, halt_q, createdump_q} <= '0;
        end else begin
            if (!stall)
                out_valid <= in_valid;      // Bubble in, bubble out
            if (accept) begin
                write_reg     <= sel_write_reg;
                read_reg_a    <= rs;
                read_reg_b    <= rt;
                imm           <= sel_imm;
                alu_src_a_q   <= alu_src_a;
                alu_src_b_q   <= alu_src_b;
                set_select_q  <= set_select;
                mem_to_reg_q  <= mem_to_reg;
                pc_dec_q      <= pc_dec;
                alu_op_q      <= alu_op;
                reg_write_q   <= reg_write;
                sign_alu_q    <= sign_alu;
                alu_res_sel_q <= alu_res_sel;
                branch_q      <= branch;
                branch_eqz_q  <= branch_eqz;
                branch_gtz_q  <= branch_gtz;
                branch_ltz_q  <= branch_ltz;
                mem_read_q    <= mem_read;
                mem_write_q   <= mem_write;
                err_q         <= err;
                halt_q        <= halt;
                createdump_q  <= createdump;
            end
        end
    end

endmodule

`default_nettype wire

//--- source/decode_top.sv
`timescale 1ns/1ps
`default_nettype none

module decode_top import decode_pkg::*; (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                in_valid,
    input  logic [WORD_W-1:0]   instr,
    input  logic                stall,
    output logic                ready,
    output logic                out_valid,
    output logic [REG_W-1:0]    write_reg, read_reg_a, read_reg_b,
    output logic [WORD_W-1:0]   imm,
    output logic [1:0]          alu_src_a_q, alu_src_b_q, set_select_q,
    output logic [1:0]          mem_to_reg_q, pc_dec_q,
    output logic [ALU_OP_W-1:0] alu_op_q,
    output logic                reg_write_q, sign_alu_q, alu_res_sel_q, branch_q,
    output logic                branch_eqz_q, branch_gtz_q, branch_ltz_q,
    output logic                mem_read_q, mem_write_q, err_q, halt_q, createdump_q
);

    // Control fields, same cycle as instr
    logic [1:0]          reg_dst, imm_sel, alu_src_a, alu_src_b;
    logic [1:0]          set_select, mem_to_reg, pc_dec;
    logic [ALU_OP_W-1:0] alu_op;
    logic                reg_write, sign_alu, alu_res_sel, branch;
    logic                branch_eqz, branch_gtz, branch_ltz;
    logic                mem_read, mem_write, err, halt, createdump;

    logic [REG_W-1:0]    rs, rt, rd_i, rd_r;
    logic [WORD_W-1:0]   imm_s5, imm_z5, imm_s8, imm_s11;

    assign ready = ~stall;  // Fetch holds instr while low

    control u_control (
        .opcode (instr[WORD_W-1 -: OP_W]),
        .*
    );

    operand_extract u_extract (
        .instr (instr),
        .*
    );

    decode_stage u_stage (.*);

endmodule

`default_nettype wire

//--- source/operand_extract.sv
`timescale 1ns/1ps
`default_nettype none

module operand_extract import decode_pkg::*; (
    input  instr_word_t       instr,
    output logic [REG_W-1:0]  rs,
    output logic [REG_W-1:0]  rt,
    output logic [REG_W-1:0]  rd_i,
    output logic [REG_W-1:0]  rd_r,
    output logic [WORD_W-1:0] imm_s5,
    output logic [WORD_W-1:0] imm_z5,
    output logic [WORD_W-1:0] imm_s8,
    output logic [WORD_W-1:0] imm_s11
);

    // rs sits in the same bits in every format but J
    assign rs   = instr.i1.rs;
    assign rt   = instr.r.rt;
    assign rd_i = instr.i1.rd;
    assign rd_r = instr.r.rd;

    // All extensions in parallel, control picks one later
    assign imm_s5  = {{(WORD_W-5){instr.i1.imm5[4]}}, instr.i1.imm5};
    assign imm_z5  = {{(WORD_W-5){1'b0}}, instr.i1.imm5};
    assign imm_s8  = {{(WORD_W-8){instr.i2.imm8[7]}}, instr.i2.imm8};
    assign imm_s11 = {{(WORD_W-11){instr.j.disp11[10]}}, instr.j.disp11};

endmodule

`default_nettype wire
